// ==== vlog.f ====
design/m26_frame_pkg.sv
design/m26_readout_pkg.sv
design/m26_rx_ch.sv
design/m26_word_merge.sv
design/m26_credit_fifo.sv
design/m26_rx_core.sv
testbench/tb_m26_rx_core.sv

// ==== Bender.yml ====
package:
  name: m26_rx

sources:
  # packages first, then lane path, merge, FIFO and top
  - files:
      - design/m26_frame_pkg.sv
      - design/m26_readout_pkg.sv
      - design/m26_rx_ch.sv
      - design/m26_word_merge.sv
      - design/m26_credit_fifo.sv
      - design/m26_rx_core.sv

  - target: test
    files:
      - testbench/tb_m26_rx_core.sv

// ==== testbench/tb_m26_rx_core.sv ====
/*
 * Both lanes carry the same frame; lane 1 trails inside the DUT.
 * Expected words are built from the frame contents and the link rules.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_m26_rx_core;

    localparam int         N_TESTS    = 8;
    localparam int         MKD_LEN    = 4;
    localparam int         FRAME_GAP  = 8;   // idle cycles after each frame
    localparam int         SETTLE     = 16;
    localparam int         KEEP_MAX   = 16 + 4; // FIFO depth plus consumer credits
    localparam logic [7:0] HEADER_BYTE = 8'h20;
    localparam logic [3:0] IDENT      = 4'h1;
    localparam logic [7:0] VERSION    = 8'd2;
    localparam logic [7:0] CONF_RESET = 8'h02;
    localparam logic [1:0] REG_CTRL    = 2'd0;
    localparam logic [1:0] REG_CONF    = 2'd1;
    localparam logic [1:0] REG_LOST    = 2'd2;
    localparam logic [1:0] REG_INVALID = 2'd3;

    typedef struct packed {
        int frames;
        int len;
        bit len_err;      // second length copy differs
        bit enable;
        bit ts_mode;
        bit mid_enable;   // enable written during the first frame
        int hold_words;   // credits withheld until this lane word (0 for never)
        bit soft_rst;
        int exp_words;
        int exp_lost;
        int exp_invalid;
        int exp_flags;
        bit exp_lost_error;
    } test_entry_t;

    test_entry_t tests [N_TESTS] = '{
        // frames len err   en    ts    mid   hold srst  words lost inv flags lerr
        '{2,     6,  1'b0, 1'b1, 1'b0, 1'b0, 0,   1'b0, 44,   0,   0,  0,    1'b0},
        '{2,     3,  1'b0, 1'b1, 1'b1, 1'b0, 0,   1'b0, 32,   0,   0,  0,    1'b0},
        '{2,     4,  1'b1, 1'b0, 1'b0, 1'b0, 0,   1'b0, 0,    0,   0,  2,    1'b0},
        '{2,     4,  1'b0, 1'b0, 1'b0, 1'b1, 0,   1'b0, 18,   0,   0,  0,    1'b0},
        '{3,     5,  1'b1, 1'b1, 1'b0, 1'b0, 0,   1'b0, 60,   0,   3,  3,    1'b0},
        '{1,     20, 1'b0, 1'b1, 1'b0, 1'b0, 12,  1'b0, 46,   4,   3,  0,    1'b1},
        '{1,     2,  1'b0, 1'b1, 1'b1, 1'b0, 0,   1'b1, 14,   0,   0,  0,    1'b0},
        '{260,   0,  1'b1, 1'b1, 1'b0, 1'b0, 0,   1'b0, 2600, 0,   255, 260, 1'b0}
    };

    logic        CLK_RX;
    logic        RST;
    logic        mkd;
    logic [1:0]  data_rx;
    logic [31:0] timestamp;
    logic        cfg_wr;
    logic        cfg_rd;
    logic [1:0]  cfg_addr;
    logic [7:0]  cfg_wdata;
    logic [7:0]  cfg_rdata;
    logic        credit_return;
    logic        out_valid;
    logic [31:0] out_word;
    logic        invalid;
    logic        invalid_flag;
    logic        lost_error;

    logic        hold_credits = 1'b0;
    int          owed = 0;
    int          flag_cnt = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lcg_state = 32'd46385;
    logic [15:0] frame_no = 16'd0;
    logic [15:0] frame_words [$];
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];

    m26_rx_core u_dut (
        .CLK_RX        (CLK_RX),
        .RST           (RST),
        .mkd           (mkd),
        .data_rx       (data_rx),
        .timestamp     (timestamp),
        .cfg_wr        (cfg_wr),
        .cfg_rd        (cfg_rd),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_word      (out_word),
        .invalid       (invalid),
        .invalid_flag  (invalid_flag),
        .lost_error    (lost_error)
    );

    initial begin
        CLK_RX = 1'b0;
        forever #50 CLK_RX = ~CLK_RX;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(posedge CLK_RX);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge CLK_RX);
        cfg_wr <= 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
        @(posedge CLK_RX);
        cfg_rd   <= 1'b1;
        cfg_addr <= addr;
        @(posedge CLK_RX);
        cfg_rd <= 1'b0;
        @(negedge CLK_RX);
        data = cfg_rdata;
    endtask

    // header, frame counter, two length copies, data, trailer
    task automatic build_frame(input int len, input bit len_err);
        frame_words.delete();
        frame_words.push_back(16'h5555);
        frame_words.push_back(frame_no);
        frame_words.push_back(len[15:0]);
        frame_words.push_back(len_err ? (len[15:0] ^ 16'h0001) : len[15:0]);
        for (int k = 0; k < len; k++)
            frame_words.push_back(lcg_next());
        frame_words.push_back(16'haa50);
        frame_no++;
    endtask

    task automatic predict_frame(input logic frame_en, input bit ts_mode,
                                 input logic [31:0] ts_val, input int hold_words,
                                 inout int kept);
        logic        lost;
        logic [15:0] d;
        lost = 1'b0;
        if (!frame_en)
            return;
        for (int w = 0; w < frame_words.size(); w++) begin
            for (int lane = 0; lane < 2; lane++) begin
                d = frame_words[w];
                if (ts_mode && w == 0)
                    d = (lane == 0) ? ts_val[15:0] : ts_val[31:16];
                if (w < hold_words && kept >= KEEP_MAX) begin
                    lost = 1'b1; // later words carry the lost bit
                end else begin
                    if (w < hold_words)
                        kept++;
                    exp_q.push_back({HEADER_BYTE, IDENT, 2'b00, lost, w == 0, d});
                end
            end
        end
    endtask

    task automatic send_frame(input logic [31:0] ts_val, input bit mid_en,
                              input logic [7:0] mid_conf, input int release_word);
        for (int c = 0; c < MKD_LEN; c++) begin
            @(posedge CLK_RX);
            mkd       <= 1'b1;
            data_rx   <= 2'b00;
            timestamp <= ts_val;
        end
        foreach (frame_words[w]) begin
            for (int b = 15; b >= 0; b--) begin
                @(posedge CLK_RX);
                mkd     <= 1'b0;
                data_rx <= {2{frame_words[w][b]}}; // MSB first
                cfg_wr  <= 1'b0;
                if (mid_en && w == 2 && b == 15) begin
                    cfg_wr    <= 1'b1;
                    cfg_addr  <= REG_CONF;
                    cfg_wdata <= mid_conf;
                end
                // mid word so well clear of the next FIFO write
                if (w == release_word && b == 7)
                    hold_credits <= 1'b0;
            end
        end
        repeat (FRAME_GAP) begin
            @(posedge CLK_RX);
            data_rx <= 2'b00;
        end
    endtask

    // consumer returns one credit per output word
    initial begin
        credit_return = 1'b0;
        forever begin
            @(posedge CLK_RX);
            if (!hold_credits && owed > 0) begin
                credit_return <= 1'b1;
                owed = owed - 1;
            end else begin
                credit_return <= 1'b0;
            end
            @(negedge CLK_RX);
            if (out_valid) begin
                got_q.push_back(out_word);
                owed = owed + 1;
            end
            if (invalid_flag)
                flag_cnt++;
        end
    end

    initial begin : watchdog
        int limit;
        limit = 2000;
        foreach (tests[i])
            limit += tests[i].frames * (tests[i].len + 5) * 16 * 4 + 200;
        repeat (limit) @(posedge CLK_RX);
        $display("timeout: run did not finish within %0d clock cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        test_entry_t t;
        logic [7:0]  rd;
        logic [7:0]  conf;
        logic [31:0] ts_val;
        logic        frame_en;
        int          kept;
        RST       = 1'b1;
        mkd       = 1'b0;
        data_rx   = 2'b00;
        timestamp = 32'd0;
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_addr  = 2'd0;
        cfg_wdata = 8'd0;
        repeat (16) @(posedge CLK_RX);
        RST <= 1'b0;
        @(negedge CLK_RX);
        check("out_valid", out_valid, 1'b0);
        check("invalid", invalid, 1'b0);
        check("invalid_flag", invalid_flag, 1'b0);
        check("lost_error", lost_error, 1'b0);
        check("cfg_rdata", cfg_rdata, 8'd0);
        read_reg(REG_CONF, rd);
        check("REG_CONF", rd, CONF_RESET);
        read_reg(REG_CTRL, rd);
        check("REG_CTRL", rd, VERSION);

        for (int i = 0; i < N_TESTS; i++) begin
            t = tests[i];
            if (t.soft_rst) begin
                write_reg(REG_CTRL, 8'h00);
                @(negedge CLK_RX);
                check("lost_error", lost_error, 1'b0);
                read_reg(REG_CONF, rd);
                check("REG_CONF", rd, CONF_RESET);
                read_reg(REG_LOST, rd);
                check("REG_LOST", rd, 8'd0);
                read_reg(REG_INVALID, rd);
                check("REG_INVALID", rd, 8'd0);
            end
            conf = {6'b0, t.ts_mode, t.enable};
            write_reg(REG_CONF, conf);
            read_reg(REG_CONF, rd);
            check("REG_CONF", rd, conf);

            got_q.delete();
            exp_q.delete();
            flag_cnt = 0;
            kept     = 0;
            hold_credits <= (t.hold_words != 0);
            for (int f = 0; f < t.frames; f++) begin
                ts_val = {lcg_next(), lcg_next()};
                build_frame(t.len, t.len_err);
                frame_en = (f > 0 && t.mid_enable) ? 1'b1 : t.enable;
                predict_frame(frame_en, t.ts_mode, ts_val, (f == 0) ? t.hold_words : 0, kept);
                send_frame(ts_val, t.mid_enable && f == 0, {6'b0, t.ts_mode, 1'b1},
                           (f == 0 && t.hold_words != 0) ? t.hold_words : -1);
            end
            hold_credits <= 1'b0;

            // wait until every credit is back before the next entry
            while (got_q.size() < t.exp_words)
                @(negedge CLK_RX);
            while (owed != 0)
                @(negedge CLK_RX);
            repeat (SETTLE) @(negedge CLK_RX);

            check($sformatf("word count, entry %0d", i), got_q.size(), t.exp_words);
            for (int k = 0; k < got_q.size() && k < exp_q.size(); k++)
                check($sformatf("out_word[%0d], entry %0d", k, i), got_q[k], exp_q[k]);
            check("invalid_flag pulses", flag_cnt, t.exp_flags);
            check("invalid", invalid, t.len_err);
            check("lost_error", lost_error, t.exp_lost_error);
            read_reg(REG_LOST, rd);
            check("REG_LOST", rd, t.exp_lost);
            read_reg(REG_INVALID, rd);
            check("REG_INVALID", rd, t.exp_invalid);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/m26_rx_core.sv ====
/*
 * Single clock receiver, all inputs sampled on CLK_RX.
 * Writing REG_CTRL resets the whole receiver, counters and config included.
 */
`timescale 1ns/1ps
`default_nettype none

module m26_rx_core
    import m26_frame_pkg::*, m26_readout_pkg::*;
(
    input  wire           CLK_RX,
    input  wire           RST,
    input  wire           mkd,
    input  wire [1:0]     data_rx,
    input  wire [31:0]    timestamp,
    input  wire           cfg_wr,
    input  wire           cfg_rd,
    input  wire [1:0]     cfg_addr,
    input  wire [7:0]     cfg_wdata,
    output logic [7:0]    cfg_rdata,
    input  wire           credit_return,
    output logic          out_valid,
    output m26_out_word_t out_word,
    output logic          invalid,
    output logic          invalid_flag,
    output logic          lost_error
);

    logic       soft_rst;
    logic       rst_int;
    logic [7:0] conf;
    logic       mkd_q;
    logic [1:0] data_q;
    logic [3:0] mkd_dly;
    logic [3:0] data1_dly;
    m26_word_t  word_ch0;
    m26_word_t  word_ch1;
    logic       inv_pulse0;
    logic       inv_pulse1;
    logic       inv_level0;
    logic       inv_level1;
    m26_entry_t entry;
    logic       wr_en;
    logic       overflow;
    logic       frame_open;
    logic       inv_frame;
    logic       inv_ff1;
    logic       inv_ff2;
    logic       inv_rise;
    logic [7:0] lost_cnt;
    logic [7:0] invalid_cnt;

    assign soft_rst = cfg_wr && (cfg_addr == REG_CTRL);
    assign rst_int  = RST | soft_rst;

    always_ff @(posedge CLK_RX) begin
        if (rst_int)
            conf <= CONF_RESET_VALUE;
        else if (cfg_wr && cfg_addr == REG_CONF)
            conf <= cfg_wdata;
    end

    always_ff @(posedge CLK_RX) begin
        if (rst_int) begin
            cfg_rdata <= '0;
        end else if (cfg_rd) begin
            case (cfg_addr)
                REG_CTRL:    cfg_rdata <= M26_VERSION;
                REG_CONF:    cfg_rdata <= conf;
                REG_LOST:    cfg_rdata <= lost_cnt;
                REG_INVALID: cfg_rdata <= invalid_cnt;
                default:     cfg_rdata <= '0;
            endcase
        end
    end

    // input registers, lane 1 trails by 4 cycles
    always_ff @(posedge CLK_RX) begin
        if (rst_int) begin
            mkd_q   <= 1'b0;
            mkd_dly <= '0;
        end else begin
            mkd_q   <= mkd;
            mkd_dly <= {mkd_dly[2:0], mkd_q};
        end
    end

    always_ff @(posedge CLK_RX) begin
        data_q    <= data_rx;
        data1_dly <= {data1_dly[2:0], data_q[1]};
    end

    m26_rx_ch u_rx_ch0 (
        .CLK_RX        (CLK_RX),
        .RST           (rst_int),
        .mkd           (mkd_q),
        .data_rx       (data_q[0]),
        .word          (word_ch0),
        .invalid_pulse (inv_pulse0),
        .invalid_level (inv_level0)
    );

    m26_rx_ch u_rx_ch1 (
        .CLK_RX        (CLK_RX),
        .RST           (rst_int),
        .mkd           (mkd_dly[3]),
        .data_rx       (data1_dly[3]),
        .word          (word_ch1),
        .invalid_pulse (inv_pulse1),
        .invalid_level (inv_level1)
    );

    m26_word_merge u_merge (
        .CLK_RX     (CLK_RX),
        .RST        (rst_int),
        .word_ch0   (word_ch0),
        .word_ch1   (word_ch1),
        .enable     (conf[0]),
        .ts_mode    (conf[1]),
        .timestamp  (timestamp),
        .overflow   (overflow),
        .entry      (entry),
        .wr_en      (wr_en),
        .frame_open (frame_open)
    );

    m26_credit_fifo u_fifo (
        .CLK_RX        (CLK_RX),
        .RST           (rst_int),
        .wr_en         (wr_en),
        .entry         (entry),
        .overflow      (overflow),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_word      (out_word)
    );

    assign invalid = inv_level0 | inv_level1;

    // invalid frame level, cleared at the next lane-0 frame start
    always_ff @(posedge CLK_RX) begin
        if (rst_int) begin
            inv_frame    <= 1'b0;
            inv_ff1      <= 1'b0;
            inv_ff2      <= 1'b0;
            invalid_flag <= 1'b0;
        end else begin
            if (word_ch0.write && word_ch0.frame_start)
                inv_frame <= 1'b0;
            else if (inv_pulse0 | inv_pulse1)
                inv_frame <= 1'b1;
            inv_ff1      <= inv_frame;
            inv_ff2      <= inv_ff1;
            invalid_flag <= inv_rise;
        end
    end

    assign inv_rise = inv_ff1 & ~inv_ff2;

    // saturating error counters
    always_ff @(posedge CLK_RX) begin
        if (rst_int) begin
            lost_cnt    <= '0;
            invalid_cnt <= '0;
            lost_error  <= 1'b0;
        end else begin
            if (overflow && lost_cnt != 8'hff)
                lost_cnt <= lost_cnt + 1'b1;
            if (inv_rise && frame_open && invalid_cnt != 8'hff)
                invalid_cnt <= invalid_cnt + 1'b1;
            lost_error <= |lost_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== design/m26_credit_fifo.sv ====
/*
 * A write into a full buffer is dropped and flagged on overflow in that cycle.
 * One output word per cycle while a credit is held; credits cap at M26_CREDIT_MAX.
 */
`timescale 1ns/1ps
`default_nettype none

module m26_credit_fifo
    import m26_readout_pkg::*;
(
    input  wire           CLK_RX,
    input  wire           RST,
    input  wire           wr_en,
    input  wire           m26_entry_t entry,
    output logic          overflow,
    input  wire           credit_return,
    output logic          out_valid,
    output m26_out_word_t out_word
);

    m26_entry_t                 mem [M26_FIFO_DEPTH];
    logic [M26_FIFO_AW:0]       wr_ptr;
    logic [M26_FIFO_AW:0]       rd_ptr;
    logic [M26_CREDIT_BITS-1:0] credits;
    logic                       full;
    logic                       empty;
    logic                       push;
    logic                       pop;

    // extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[M26_FIFO_AW] != rd_ptr[M26_FIFO_AW]) &&
                   (wr_ptr[M26_FIFO_AW-1:0] == rd_ptr[M26_FIFO_AW-1:0]);

    assign push     = wr_en && !full;
    assign overflow = wr_en && full;
    assign pop      = !empty && (credits != '0);

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (push)
            mem[wr_ptr[M26_FIFO_AW-1:0]] <= entry;
    end

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            credits <= M26_CREDIT_BITS'(M26_CREDIT_MAX);
        end else begin
            case ({pop, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (credits != M26_CREDIT_BITS'(M26_CREDIT_MAX))
                        credits <= credits + 1'b1;
                end
                default: ; // both or neither, count unchanged
            endcase
        end
    end

    // output stage
    always_ff @(posedge CLK_RX) begin
        if (RST)
            out_valid <= 1'b0;
        else
            out_valid <= pop;
    end

    always_ff @(posedge CLK_RX) begin
        if (pop) begin
            out_word <= '{header_byte: M26_HEADER_BYTE,
                          ident:       M26_IDENT,
                          reserved:    2'b00,
                          entry:       mem[rd_ptr[M26_FIFO_AW-1:0]]};
        end
    end

endmodule

`default_nettype wire

// ==== design/m26_word_merge.sv ====
/*
 * Lane 0 wins if both lanes complete a word in the same cycle.
 * Enable and timestamp mode take effect at the next lane-0 frame start.
 */
`timescale 1ns/1ps
`default_nettype none

module m26_word_merge
    import m26_frame_pkg::*, m26_readout_pkg::*;
(
    input  wire        CLK_RX,
    input  wire        RST,
    input  wire        m26_word_t word_ch0,
    input  wire        m26_word_t word_ch1,
    input  wire        enable,
    input  wire        ts_mode,
    input  wire [31:0] timestamp,
    input  wire        overflow,
    output m26_entry_t entry,
    output logic       wr_en,
    output logic       frame_open
);

    logic        ch0_start;
    logic        ch1_start;
    logic [15:0] ts_hi;
    logic [15:0] data_q;
    logic        fs_q;
    logic        wr_q;
    logic        lost_q;

    assign ch0_start = word_ch0.write && word_ch0.frame_start;
    assign ch1_start = word_ch1.write && word_ch1.frame_start;

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            frame_open <= 1'b0;
            wr_q       <= 1'b0;
            lost_q     <= 1'b0;
        end else begin
            wr_q <= word_ch0.write | word_ch1.write;
            if (ch0_start)
                frame_open <= enable; // whole frames only
            if (ch0_start)
                lost_q <= 1'b0;
            else if (overflow)
                lost_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (ch0_start)
            ts_hi <= timestamp[31:16]; // for the lane-1 header
        if (word_ch0.write) begin
            data_q <= (ts_mode && word_ch0.frame_start) ? timestamp[15:0] : word_ch0.data;
            fs_q   <= word_ch0.frame_start;
        end else if (word_ch1.write) begin
            data_q <= (ts_mode && ch1_start) ? ts_hi : word_ch1.data;
            fs_q   <= word_ch1.frame_start;
        end
    end

    assign wr_en = wr_q && frame_open;
    assign entry = '{lost: lost_q, frame_start: fs_q, data: data_q};

endmodule

`default_nettype wire

// ==== design/m26_rx_ch.sv ====
/*
 * Header MSB must follow the fourth marker sample directly; a longer marker
 * does not restart. Data length comes from the first copy, clamped to M26_MAX_LEN.
 */
`timescale 1ns/1ps
`default_nettype none

module m26_rx_ch
    import m26_frame_pkg::*;
(
    input  wire       CLK_RX,
    input  wire       RST,
    input  wire       mkd,
    input  wire       data_rx,
    output m26_word_t word,
    output logic      invalid_pulse,
    output logic      invalid_level
);

    logic [M26_MKD_CNT_BITS-1:0] mkd_cnt;
    logic                        start;
    logic                        active;
    logic [M26_BIT_CNT_BITS-1:0] bit_cnt;
    logic [M26_WCNT_BITS-1:0]    word_cnt;
    logic [M26_WCNT_BITS-1:0]    last_idx;
    logic [M26_WCNT_BITS-1:0]    data_len;
    logic [M26_WORD_BITS-1:0]    sr;
    logic [M26_WORD_BITS-1:0]    cur_word;
    logic [M26_WORD_BITS-1:0]    len0;
    logic                        word_done;
    logic                        len_bad;
    logic [M26_WORD_BITS-1:0]    word_data;
    logic                        word_fs;
    logic                        word_wr;

    // fourth consecutive high marker sample
    assign start = mkd && (mkd_cnt == M26_MKD_CNT_BITS'(M26_MKD_LEN - 1));

    assign cur_word  = {sr[M26_WORD_BITS-2:0], data_rx}; // MSB first
    assign word_done = active && (bit_cnt == M26_BIT_CNT_BITS'(M26_WORD_BITS - 1));

    assign len_bad  = (cur_word != len0) || (len0 > M26_MAX_LEN);
    assign data_len = (len0 > M26_MAX_LEN) ? M26_WCNT_BITS'(M26_MAX_LEN)
                                           : len0[M26_WCNT_BITS-1:0];

    always_ff @(posedge CLK_RX) begin
        if (RST)
            mkd_cnt <= '0;
        else if (!mkd)
            mkd_cnt <= '0;
        else if (mkd_cnt != M26_MKD_CNT_BITS'(M26_MKD_LEN))
            mkd_cnt <= mkd_cnt + 1'b1; // saturates, no retrigger
    end

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            active        <= 1'b0;
            bit_cnt       <= '0;
            word_cnt      <= '0;
            word_wr       <= 1'b0;
            invalid_pulse <= 1'b0;
            invalid_level <= 1'b0;
        end else begin
            word_wr       <= word_done;
            invalid_pulse <= 1'b0;
            if (start) begin
                active        <= 1'b1;
                bit_cnt       <= '0;
                word_cnt      <= '0;
                invalid_level <= 1'b0;
            end else if (active) begin
                bit_cnt <= word_done ? '0 : bit_cnt + 1'b1;
                if (word_done) begin
                    word_cnt <= word_cnt + 1'b1;
                    // second length copy
                    if (word_cnt == M26_WCNT_BITS'(3) && len_bad) begin
                        invalid_pulse <= 1'b1;
                        invalid_level <= 1'b1;
                    end
                    if (word_cnt > M26_WCNT_BITS'(3) && word_cnt == last_idx)
                        active <= 1'b0; // trailer done
                end
            end
        end
    end

    always_ff @(posedge CLK_RX) begin
        sr <= cur_word;
        if (word_done) begin
            word_data <= cur_word;
            word_fs   <= (word_cnt == '0);
            if (word_cnt == M26_WCNT_BITS'(2))
                len0 <= cur_word;
            if (word_cnt == M26_WCNT_BITS'(3))
                last_idx <= data_len + M26_WCNT_BITS'(4); // trailer index
        end
    end

    assign word = '{data: word_data, frame_start: word_fs, write: word_wr};

endmodule

`default_nettype wire

// ==== design/m26_readout_pkg.sv ====
/*
 * Readout-side constants: FIFO entry, output word layout, register map.
 * FIFO depth must be a power of two.
 */
`default_nettype none

package m26_readout_pkg;

    localparam logic [7:0] M26_VERSION     = 8'd2;
    localparam logic [7:0] M26_HEADER_BYTE = 8'h20;
    localparam logic [3:0] M26_IDENT       = 4'h1;

    localparam int M26_FIFO_DEPTH  = 16;
    localparam int M26_FIFO_AW     = $clog2(M26_FIFO_DEPTH);
    localparam int M26_CREDIT_MAX  = 4; // credits the consumer may hold back
    localparam int M26_CREDIT_BITS = $clog2(M26_CREDIT_MAX + 1);

    // register map
    localparam logic [1:0] REG_CTRL    = 2'd0; // write: soft reset, read: version
    localparam logic [1:0] REG_CONF    = 2'd1; // bit0 enable, bit1 timestamp mode
    localparam logic [1:0] REG_LOST    = 2'd2;
    localparam logic [1:0] REG_INVALID = 2'd3;

    localparam logic [7:0] CONF_RESET_VALUE = 8'h02;

    typedef struct packed {
        logic        lost;        // words dropped earlier in this frame
        logic        frame_start;
        logic [15:0] data;
    } m26_entry_t;

    typedef struct packed {
        logic [7:0] header_byte;
        logic [3:0] ident;
        logic [1:0] reserved;  // always zero
        m26_entry_t entry;
    } m26_out_word_t;

endpackage

`default_nettype wire

// ==== design/m26_frame_pkg.sv ====
/*
 * Lane-side constants and the deserialized word type.
 * One lane frame is header, frame counter, two length copies, data words, trailer.
 */
`default_nettype none

package m26_frame_pkg;

    localparam int M26_WORD_BITS = 16;  // bits per lane word
    localparam int M26_MKD_LEN   = 4;   // marker samples before a frame
    localparam int M26_MAX_LEN   = 570; // largest legal data length

    // counter widths
    localparam int M26_MKD_CNT_BITS = $clog2(M26_MKD_LEN + 1);
    localparam int M26_BIT_CNT_BITS = $clog2(M26_WORD_BITS);
    // enough for header words, maximum length and trailer
    localparam int M26_WCNT_BITS    = $clog2(M26_MAX_LEN + 5 + 1);

    typedef struct packed {
        logic [M26_WORD_BITS-1:0] data;
        logic                     frame_start; // header word
        logic                     write;       // word complete, one cycle
    } m26_word_t;

endpackage

`default_nettype wire
